// ==== hdl/skdecode_pkg.sv ====
// ML-DSA secret-key decode definitions
// Modulus, memory widths, request format and FSM state encodings

`default_nettype none

package skdecode_pkg;

    // Modulus q
    localparam logic [22:0] MLDSA_Q = 23'd8380417;
    localparam int MLDSA_MEM_ADDR_WIDTH = 12;

    typedef logic [MLDSA_MEM_ADDR_WIDTH-1:0] kmem_addr_t;
    typedef logic [MLDSA_MEM_ADDR_WIDTH-1:0] dmem_addr_t;
    typedef logic [31:0] kword_t;
    typedef logic [23:0] coeff_t;
    // Four coefficients, lowest first
    typedef logic [95:0] dword_t;

    typedef enum logic [1:0] {
        RW_IDLE  = 2'd0,
        RW_READ  = 2'd1,
        RW_WRITE = 2'd2
    } mem_rw_mode_e;

    typedef struct packed {
        mem_rw_mode_e                    rd_wr_en;
        logic [MLDSA_MEM_ADDR_WIDTH-1:0] addr;
    } mem_if_t;

    typedef enum logic [2:0] {
        SKDEC_RD_IDLE,
        SKDEC_RD_S1,
        SKDEC_RD_S2,
        SKDEC_RD_T0,
        SKDEC_RD_STAGE
    } skdec_read_state_e;

    typedef enum logic [2:0] {
        SKDEC_WR_IDLE,
        SKDEC_WR_S1,
        SKDEC_WR_S2,
        SKDEC_WR_T0,
        SKDEC_WR_STAGE
    } skdec_write_state_e;

endpackage

`default_nettype wire

// ==== hdl/skdecode_ctrl.sv ====
// Secret-key decode control
// Read FSM streams the key out of memory, the lagging write FSM
// turns unpacker valids into destination bank writes

`timescale 1ns/1ps
`default_nettype none

module skdecode_ctrl
    import skdecode_pkg::*;
#(
    parameter int MLDSA_L = 7,
    parameter int MLDSA_K = 8,
    parameter int MLDSA_N = 256
) (
    input  wire             clk,
    input  wire             reset_n,
    input  wire             zeroize,
    input  wire             skdecode_enable,
    input  wire kmem_addr_t src_base_addr,
    input  wire dmem_addr_t dest_base_addr,
    input  wire             s1s2_valid,
    input  wire             t0_valid,
    input  wire             t0_buf_stall,
    output mem_if_t         kmem_a_rd_req,
    output mem_if_t         kmem_b_rd_req,
    output mem_if_t         mem_a_wr_req,
    output mem_if_t         mem_b_wr_req,
    output logic            s1s2_enable,
    output logic            t0_enable,
    output logic            s1s2_buf_stall,
    output logic            skdecode_done,
    output logic            s1_done,
    output logic            s2_done,
    output logic            t0_done
);

    // Last count of each section
    localparam logic [9:0] S1_LAST = 10'(MLDSA_L * MLDSA_N / 8 - 1);
    localparam logic [9:0] S2_LAST = 10'(MLDSA_K * MLDSA_N / 8 - 1);
    localparam logic [9:0] T0_LAST = 10'(MLDSA_K * MLDSA_N * 13 / 64 - 1);

    skdec_read_state_e  rd_state;
    skdec_read_state_e  rd_state_nxt;
    skdec_write_state_e wr_state;
    skdec_write_state_e wr_state_nxt;

    kmem_addr_t rd_addr;
    dmem_addr_t wr_grp;
    dmem_addr_t wr_addr;
    logic [9:0] sec_count;
    logic [9:0] sec_last;
    logic [1:0] stall_count;
    logic       start;
    logic       s1s2_mode_rd;
    logic       t0_mode_rd;
    logic       s1s2_stall_nxt;
    logic       rd_issue;
    logic       sec_end;
    logic       wr_s1s2;
    logic       wr_drained;
    logic       wr_t0_leave;
    logic       wr_s1s2_fire;
    logic       wr_t0_fire;

    assign start         = skdecode_enable & (wr_state == SKDEC_WR_IDLE);
    assign skdecode_done = (wr_state == SKDEC_WR_IDLE);

    // ------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------
    always_comb begin
        s1s2_mode_rd   = (rd_state == SKDEC_RD_S1) | (rd_state == SKDEC_RD_S2);
        t0_mode_rd     = (rd_state == SKDEC_RD_T0);
        // One idle slot in four while unpacking eta coefficients
        s1s2_stall_nxt = s1s2_mode_rd & (stall_count == 2'd3);
        rd_issue       = (s1s2_mode_rd & ~s1s2_stall_nxt) | (t0_mode_rd & ~t0_buf_stall);
        unique case (rd_state)
            SKDEC_RD_S1: sec_last = S1_LAST;
            SKDEC_RD_S2: sec_last = S2_LAST;
            default:     sec_last = T0_LAST;
        endcase
        // s1/s2 count cycles, t0 counts issued reads
        sec_end = (sec_count == sec_last) & (s1s2_mode_rd | (t0_mode_rd & rd_issue));
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr     <= '0;
            sec_count   <= '0;
            stall_count <= '0;
        end else if (zeroize || rd_state == SKDEC_RD_IDLE) begin
            rd_addr     <= '0;
            sec_count   <= '0;
            stall_count <= '0;
        end else begin
            // Address runs on across sections
            if (rd_issue)
                rd_addr <= rd_addr + (t0_mode_rd ? kmem_addr_t'(2) : kmem_addr_t'(1));
            if (s1s2_mode_rd)
                stall_count <= stall_count + 2'd1;
            if (sec_end)
                sec_count <= '0;
            else if (s1s2_mode_rd || rd_issue)
                sec_count <= sec_count + 10'd1;
        end
    end

    always_comb begin
        rd_state_nxt = rd_state;
        unique case (rd_state)
            SKDEC_RD_IDLE: begin
                if (skdecode_enable)
                    rd_state_nxt = SKDEC_RD_S1;
            end
            SKDEC_RD_S1, SKDEC_RD_S2, SKDEC_RD_T0: begin
                if (sec_end)
                    rd_state_nxt = SKDEC_RD_STAGE;
            end
            SKDEC_RD_STAGE: begin
                // Wait here for the write side to catch up
                if (wr_state == SKDEC_WR_STAGE)
                    rd_state_nxt = s2_done ? SKDEC_RD_T0 : SKDEC_RD_S2;
                else if (wr_t0_leave)
                    rd_state_nxt = SKDEC_RD_IDLE;
            end
            default: rd_state_nxt = SKDEC_RD_IDLE;
        endcase
    end

    // ------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------
    always_comb begin
        wr_s1s2      = (wr_state == SKDEC_WR_S1) | (wr_state == SKDEC_WR_S2);
        wr_s1s2_fire = wr_s1s2 & s1s2_valid;
        wr_t0_fire   = (wr_state == SKDEC_WR_T0) & t0_valid;
        // Last read data is still in flight on the first STAGE cycle
        wr_drained   = (rd_state == SKDEC_RD_STAGE) & ~s1s2_enable & ~t0_enable &
                       ~s1s2_valid & ~t0_valid;
        wr_t0_leave  = (wr_state == SKDEC_WR_T0) & wr_drained;
    end

    always_comb begin
        wr_state_nxt = wr_state;
        unique case (wr_state)
            SKDEC_WR_IDLE: begin
                if (skdecode_enable)
                    wr_state_nxt = SKDEC_WR_S1;
            end
            SKDEC_WR_S1, SKDEC_WR_S2: begin
                if (wr_drained)
                    wr_state_nxt = SKDEC_WR_STAGE;
            end
            SKDEC_WR_T0: begin
                if (wr_drained)
                    wr_state_nxt = SKDEC_WR_IDLE;
            end
            SKDEC_WR_STAGE: wr_state_nxt = s2_done ? SKDEC_WR_T0 : SKDEC_WR_S2;
            default:        wr_state_nxt = SKDEC_WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state <= SKDEC_RD_IDLE;
            wr_state <= SKDEC_WR_IDLE;
        end else if (zeroize) begin
            rd_state <= SKDEC_RD_IDLE;
            wr_state <= SKDEC_WR_IDLE;
        end else begin
            rd_state <= rd_state_nxt;
            wr_state <= wr_state_nxt;
        end
    end

    // Destination group number, shared by all three sections
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            wr_grp <= '0;
        else if (zeroize || wr_state == SKDEC_WR_IDLE)
            wr_grp <= '0;
        else if (wr_s1s2_fire)
            wr_grp <= wr_grp + dmem_addr_t'(2);
        else if (wr_t0_fire)
            wr_grp <= wr_grp + dmem_addr_t'(1);
    end

    // Sticky section flags, cleared by the next start
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_done <= 1'b0;
            s2_done <= 1'b0;
            t0_done <= 1'b0;
        end else if (zeroize || start) begin
            s1_done <= 1'b0;
            s2_done <= 1'b0;
            t0_done <= 1'b0;
        end else begin
            if (wr_state == SKDEC_WR_S1 && wr_drained)
                s1_done <= 1'b1;
            if (wr_state == SKDEC_WR_S2 && wr_drained)
                s2_done <= 1'b1;
            if (wr_t0_leave)
                t0_done <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Memory requests
    // ------------------------------------------------------------------
    always_comb begin
        wr_addr = dest_base_addr + (wr_grp >> 1);

        kmem_a_rd_req.rd_wr_en = rd_issue ? RW_READ : RW_IDLE;
        kmem_a_rd_req.addr     = src_base_addr + rd_addr;
        // Port b only helps out in t0, one word ahead
        kmem_b_rd_req.rd_wr_en = (rd_issue & t0_mode_rd) ? RW_READ : RW_IDLE;
        kmem_b_rd_req.addr     = src_base_addr + rd_addr + kmem_addr_t'(1);

        mem_a_wr_req.addr      = wr_addr;
        mem_a_wr_req.rd_wr_en  = (wr_s1s2_fire | (wr_t0_fire & ~wr_grp[0])) ?
                                 RW_WRITE : RW_IDLE;
        mem_b_wr_req.addr      = wr_addr;
        mem_b_wr_req.rd_wr_en  = (wr_s1s2_fire | (wr_t0_fire & wr_grp[0])) ?
                                 RW_WRITE : RW_IDLE;
    end

    // Delayed one cycle to meet the returning read data
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1s2_enable    <= 1'b0;
            t0_enable      <= 1'b0;
            s1s2_buf_stall <= 1'b0;
        end else if (zeroize) begin
            s1s2_enable    <= 1'b0;
            t0_enable      <= 1'b0;
            s1s2_buf_stall <= 1'b0;
        end else begin
            s1s2_enable    <= s1s2_mode_rd;
            t0_enable      <= t0_mode_rd & ~t0_buf_stall;
            s1s2_buf_stall <= s1s2_stall_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/skdecode_s1s2_unpack.sv ====
// s1/s2 unpacker
// Repacks 32-bit key words into groups of eight 3-bit eta values,
// maps each to 2 - v mod q and flags values above 4

`timescale 1ns/1ps
`default_nettype none

module skdecode_s1s2_unpack
    import skdecode_pkg::*;
(
    input  wire         clk,
    input  wire         reset_n,
    input  wire         zeroize,
    input  wire         s1s2_enable,
    input  wire         s1s2_buf_stall,
    input  wire kword_t kmem_rd_data,
    output logic        s1s2_valid,
    output dword_t      s1s2_lo_word,
    output dword_t      s1s2_hi_word,
    output logic        s1s2_error
);

    logic [55:0] buf_q;
    logic [55:0] buf_drained;
    logic [55:0] buf_nxt;
    logic [5:0]  cnt;
    logic [5:0]  cnt_drained;
    logic        take;
    logic        en_d;
    logic        in_s2;
    logic        grp_bad;
    coeff_t      coeff [8];

    function automatic coeff_t eta_map(input logic [2:0] v);
        coeff_t d;
        d = coeff_t'(2) - coeff_t'(v);
        if (v > 3'd2)
            d = d + coeff_t'(MLDSA_Q);
        return d;
    endfunction

    always_comb begin
        take        = s1s2_enable & ~s1s2_buf_stall;
        s1s2_valid  = (cnt >= 6'd24);
        buf_drained = s1s2_valid ? (buf_q >> 24) : buf_q;
        cnt_drained = s1s2_valid ? cnt - 6'd24 : cnt;
        buf_nxt     = buf_drained;
        if (take)
            buf_nxt = buf_drained | (56'(kmem_rd_data) << cnt_drained);

        grp_bad = 1'b0;
        for (int i = 0; i < 8; i++) begin
            coeff[i] = eta_map(buf_q[3*i +: 3]);
            grp_bad  = grp_bad | (buf_q[3*i +: 3] > 3'd4);
        end
        s1s2_lo_word = {coeff[3], coeff[2], coeff[1], coeff[0]};
        s1s2_hi_word = {coeff[7], coeff[6], coeff[5], coeff[4]};
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            buf_q      <= '0;
            cnt        <= '0;
            en_d       <= 1'b0;
            in_s2      <= 1'b0;
            s1s2_error <= 1'b0;
        end else if (zeroize) begin
            buf_q      <= '0;
            cnt        <= '0;
            en_d       <= 1'b0;
            in_s2      <= 1'b0;
            s1s2_error <= 1'b0;
        end else begin
            buf_q <= buf_nxt;
            cnt   <= cnt_drained + (take ? 6'd32 : 6'd0);
            en_d  <= s1s2_enable;
            // Enable rises once for s1 and once for s2 in every run
            if (s1s2_enable && !en_d)
                in_s2 <= ~in_s2;
            if (s1s2_enable && !en_d && !in_s2)
                s1s2_error <= 1'b0;
            else if (s1s2_valid && grp_bad)
                s1s2_error <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/skdecode_t0_unpack.sv ====
// t0 sample buffer
// Takes 64 key bits per enabled cycle and emits groups of four 13-bit
// values mapped to 4096 - v mod q, stalling the reads when nearly full

`timescale 1ns/1ps
`default_nettype none

module skdecode_t0_unpack
    import skdecode_pkg::*;
(
    input  wire         clk,
    input  wire         reset_n,
    input  wire         zeroize,
    input  wire         t0_enable,
    input  wire kword_t kmem_a_rd_data,
    input  wire kword_t kmem_b_rd_data,
    output logic        t0_valid,
    output dword_t      t0_word,
    output logic        t0_buf_stall
);

    logic [127:0] buf_q;
    logic [127:0] buf_drained;
    logic [7:0]   cnt;
    logic [7:0]   cnt_drained;
    logic [7:0]   cnt_nxt;
    coeff_t       coeff [4];

    function automatic coeff_t t0_map(input logic [12:0] v);
        coeff_t d;
        d = coeff_t'(4096) - coeff_t'(v);
        if (v > 13'd4096)
            d = d + coeff_t'(MLDSA_Q);
        return d;
    endfunction

    always_comb begin
        t0_valid    = (cnt >= 8'd52);
        buf_drained = t0_valid ? (buf_q >> 52) : buf_q;
        cnt_drained = t0_valid ? cnt - 8'd52 : cnt;
        cnt_nxt     = t0_enable ? cnt_drained + 8'd64 : cnt_drained;

        // A read issued now lands after one more drain of 52 bits,
        // so 116 bits is the most that still leaves room for 64
        t0_buf_stall = (cnt_nxt > 8'd116);

        for (int i = 0; i < 4; i++)
            coeff[i] = t0_map(buf_q[13*i +: 13]);
        t0_word = {coeff[3], coeff[2], coeff[1], coeff[0]};
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            buf_q <= '0;
            cnt   <= '0;
        end else if (zeroize) begin
            buf_q <= '0;
            cnt   <= '0;
        end else begin
            cnt <= cnt_nxt;
            // Port a holds the lower word
            if (t0_enable)
                buf_q <= buf_drained |
                         (128'({kmem_b_rd_data, kmem_a_rd_data}) << cnt_drained);
            else
                buf_q <= buf_drained;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/skdecode_top.sv ====
// Secret-key decode top level
// Joins the control block to the s1/s2 and t0 unpackers and steers
// their coefficient words to the two destination banks

`timescale 1ns/1ps
`default_nettype none

module skdecode_top
    import skdecode_pkg::*;
#(
    parameter int MLDSA_L = 7,
    parameter int MLDSA_K = 8,
    parameter int MLDSA_N = 256
) (
    input  wire             clk,
    input  wire             reset_n,
    input  wire             zeroize,
    input  wire             skdecode_enable,
    input  wire kmem_addr_t src_base_addr,
    input  wire dmem_addr_t dest_base_addr,
    input  wire kword_t     kmem_a_rd_data,
    input  wire kword_t     kmem_b_rd_data,
    output mem_if_t         kmem_a_rd_req,
    output mem_if_t         kmem_b_rd_req,
    output mem_if_t         mem_a_wr_req,
    output mem_if_t         mem_b_wr_req,
    output dword_t          mem_a_wr_data,
    output dword_t          mem_b_wr_data,
    output logic            skdecode_done,
    output logic            s1_done,
    output logic            s2_done,
    output logic            t0_done,
    output logic            skdecode_error
);

    logic   s1s2_enable;
    logic   s1s2_buf_stall;
    logic   s1s2_valid;
    logic   t0_enable;
    logic   t0_valid;
    logic   t0_buf_stall;
    dword_t s1s2_lo_word;
    dword_t s1s2_hi_word;
    dword_t t0_word;

    skdecode_ctrl #(
        .MLDSA_L (MLDSA_L),
        .MLDSA_K (MLDSA_K),
        .MLDSA_N (MLDSA_N)
    ) u_ctrl (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize         (zeroize),
        .skdecode_enable (skdecode_enable),
        .src_base_addr   (src_base_addr),
        .dest_base_addr  (dest_base_addr),
        .s1s2_valid      (s1s2_valid),
        .t0_valid        (t0_valid),
        .t0_buf_stall    (t0_buf_stall),
        .kmem_a_rd_req   (kmem_a_rd_req),
        .kmem_b_rd_req   (kmem_b_rd_req),
        .mem_a_wr_req    (mem_a_wr_req),
        .mem_b_wr_req    (mem_b_wr_req),
        .s1s2_enable     (s1s2_enable),
        .t0_enable       (t0_enable),
        .s1s2_buf_stall  (s1s2_buf_stall),
        .skdecode_done   (skdecode_done),
        .s1_done         (s1_done),
        .s2_done         (s2_done),
        .t0_done         (t0_done)
    );

    skdecode_s1s2_unpack u_s1s2 (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .s1s2_enable    (s1s2_enable),
        .s1s2_buf_stall (s1s2_buf_stall),
        .kmem_rd_data   (kmem_a_rd_data),
        .s1s2_valid     (s1s2_valid),
        .s1s2_lo_word   (s1s2_lo_word),
        .s1s2_hi_word   (s1s2_hi_word),
        .s1s2_error     (skdecode_error)
    );

    skdecode_t0_unpack u_t0 (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .t0_enable      (t0_enable),
        .kmem_a_rd_data (kmem_a_rd_data),
        .kmem_b_rd_data (kmem_b_rd_data),
        .t0_valid       (t0_valid),
        .t0_word        (t0_word),
        .t0_buf_stall   (t0_buf_stall)
    );

    // s1/s2 fill both banks at once, t0 goes to one bank at a time
    always_comb begin
        mem_a_wr_data = s1s2_valid ? s1s2_lo_word : t0_word;
        mem_b_wr_data = s1s2_valid ? s1s2_hi_word : t0_word;
    end

endmodule

`default_nettype wire

// ==== bench/skdecode_clkgen.sv ====
// Testbench clock and reset source
// 4 ns clock, reset_n held low for the first 16 cycles

`timescale 1ns/1ps
`default_nettype none

module skdecode_clkgen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release on a falling edge, away from the DUT's sampling edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/skdecode_props.sv ====
// Control block checks
// Key port b use, reads under t0 stall, and done against bank writes

`timescale 1ns/1ps
`default_nettype none

module skdecode_props
    import skdecode_pkg::*;
(
    input wire          clk,
    input wire          reset_n,
    input wire mem_if_t kmem_a_rd_req,
    input wire mem_if_t kmem_b_rd_req,
    input wire          s1s2_valid,
    input wire          t0_valid,
    input wire          t0_buf_stall,
    input wire          skdecode_done,
    input wire          s2_done,
    input wire          t0_done
);

    // Port b reads fall between s2_done and t0_done
    port_b_in_t0: assert property (@(posedge clk) disable iff (!reset_n)
        (kmem_b_rd_req.rd_wr_en == RW_READ) |-> (s2_done && !t0_done))
    else $error("key port b read outside the t0 section");

    // Full sample buffer holds the read address
    no_read_in_stall: assert property (@(posedge clk) disable iff (!reset_n)
        t0_buf_stall |-> (kmem_a_rd_req.rd_wr_en != RW_READ &&
                          kmem_b_rd_req.rd_wr_en != RW_READ))
    else $error("key read issued while the t0 buffer is full");

    // Unpacker valids are the bank write requests
    no_write_when_done: assert property (@(posedge clk) disable iff (!reset_n)
        skdecode_done |-> (!s1s2_valid && !t0_valid))
    else $error("destination write requested while decode reports done");

endmodule

`default_nettype wire

// ==== bench/skdecode_tb.sv ====
// Secret-key decode testbench
// Models the key memory and both destination banks, runs a table of cases
// and checks every decoded coefficient against the mod q mapping

`timescale 1ns/1ps
`default_nettype none

module skdecode_tb
    import skdecode_pkg::*;
#(
    parameter int L = 2,
    parameter int K = 2,
    parameter int N = 64
) ();

    localparam int Q_MOD     = 8380417;
    localparam int S_COEFFS  = (L + K) * N;
    localparam int T_COEFFS  = K * N;
    localparam int N_COEFFS  = S_COEFFS + T_COEFFS;
    localparam int N_GROUPS  = N_COEFFS / 4;
    localparam int KEY_WORDS = (S_COEFFS * 3 + T_COEFFS * 13) / 32;
    localparam int TIMEOUT   = 2000;
    localparam int NUM_CASES = 6;

    typedef struct packed {
        kmem_addr_t src;
        dmem_addr_t dest;
        logic       bad;
        logic       zmid;
    } case_t;

    // Source base, destination base, bad s1 value, zeroize midway
    case_t cases [NUM_CASES] = '{
        '{12'h000, 12'h000, 1'b0, 1'b0},
        '{12'h040, 12'h101, 1'b0, 1'b0},
        '{12'h123, 12'h2a0, 1'b1, 1'b0},
        '{12'h010, 12'h008, 1'b0, 1'b0},
        '{12'h200, 12'h050, 1'b0, 1'b1},
        '{12'h3a0, 12'h3c0, 1'b1, 1'b1}
    };

    logic       clk;
    logic       reset_n;
    logic       zeroize;
    logic       skdecode_enable;
    kmem_addr_t src_base_addr;
    dmem_addr_t dest_base_addr;
    kword_t     kmem_a_rd_data = '0;
    kword_t     kmem_b_rd_data = '0;
    mem_if_t    kmem_a_rd_req;
    mem_if_t    kmem_b_rd_req;
    mem_if_t    mem_a_wr_req;
    mem_if_t    mem_b_wr_req;
    dword_t     mem_a_wr_data;
    dword_t     mem_b_wr_data;
    logic       skdecode_done;
    logic       s1_done;
    logic       s2_done;
    logic       t0_done;
    logic       skdecode_error;
    logic       bank_clear = 1'b0;

    kword_t kmem [1024];
    dword_t bank_a [4096];
    dword_t bank_b [4096];
    coeff_t exp_coeff [N_COEFFS];

    skdecode_clkgen u_clkgen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    skdecode_top #(
        .MLDSA_L (L),
        .MLDSA_K (K),
        .MLDSA_N (N)
    ) u_dut (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize         (zeroize),
        .skdecode_enable (skdecode_enable),
        .src_base_addr   (src_base_addr),
        .dest_base_addr  (dest_base_addr),
        .kmem_a_rd_data  (kmem_a_rd_data),
        .kmem_b_rd_data  (kmem_b_rd_data),
        .kmem_a_rd_req   (kmem_a_rd_req),
        .kmem_b_rd_req   (kmem_b_rd_req),
        .mem_a_wr_req    (mem_a_wr_req),
        .mem_b_wr_req    (mem_b_wr_req),
        .mem_a_wr_data   (mem_a_wr_data),
        .mem_b_wr_data   (mem_b_wr_data),
        .skdecode_done   (skdecode_done),
        .s1_done         (s1_done),
        .s2_done         (s2_done),
        .t0_done         (t0_done),
        .skdecode_error  (skdecode_error)
    );

    bind skdecode_ctrl skdecode_props u_props (
        .clk           (clk),
        .reset_n       (reset_n),
        .kmem_a_rd_req (kmem_a_rd_req),
        .kmem_b_rd_req (kmem_b_rd_req),
        .s1s2_valid    (s1s2_valid),
        .t0_valid      (t0_valid),
        .t0_buf_stall  (t0_buf_stall),
        .skdecode_done (skdecode_done),
        .s2_done       (s2_done),
        .t0_done       (t0_done)
    );

    // ----------------------------------------------------------------------
    // Memory models
    // ----------------------------------------------------------------------
    function automatic dword_t fill_word(input int bank, input int addr);
        return {8'hf0, 8'(bank), 16'(addr), 32'(addr) ^ 32'h6b2d_0000, 32'(~addr)};
    endfunction

    // Key reads return one cycle after the request
    always @(posedge clk) begin
        if (kmem_a_rd_req.rd_wr_en == RW_READ)
            kmem_a_rd_data <= kmem[kmem_a_rd_req.addr[9:0]];
        if (kmem_b_rd_req.rd_wr_en == RW_READ)
            kmem_b_rd_data <= kmem[kmem_b_rd_req.addr[9:0]];
        if (bank_clear) begin
            for (int i = 0; i < 4096; i++) begin
                bank_a[i] <= fill_word(0, i);
                bank_b[i] <= fill_word(1, i);
            end
        end else begin
            if (mem_a_wr_req.rd_wr_en == RW_WRITE)
                bank_a[mem_a_wr_req.addr] <= mem_a_wr_data;
            if (mem_b_wr_req.rd_wr_en == RW_WRITE)
                bank_b[mem_b_wr_req.addr] <= mem_b_wr_data;
        end
    end

    // ----------------------------------------------------------------------
    // Checks and waits
    // ----------------------------------------------------------------------
    task automatic check_value(input logic [95:0] got, input logic [95:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    endtask

    function automatic coeff_t ref_coeff(input int offset, input int v);
        int r;
        r = (offset - v) % Q_MOD;
        if (r < 0)
            r = r + Q_MOD;
        return coeff_t'(r);
    endfunction

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (reset_n !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT)
                fail_timeout("reset release");
        end
    endtask

    task automatic wait_s1_done();
        int n;
        n = 0;
        while (s1_done !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT)
                fail_timeout("s1_done");
        end
    endtask

    // Later section flags never run ahead of earlier ones
    task automatic wait_run_end();
        int n;
        n = 0;
        while (t0_done !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT)
                fail_timeout("t0_done");
            check_value(96'(s2_done & ~s1_done), 96'(0), "s2_done before s1_done");
            check_value(96'(t0_done & ~s2_done), 96'(0), "t0_done before s2_done");
            check_value(96'(skdecode_done), 96'(t0_done), "skdecode_done against t0_done");
        end
    endtask

    task automatic check_idle(input string when_s);
        check_value(96'({kmem_a_rd_req.rd_wr_en, kmem_b_rd_req.rd_wr_en,
                         mem_a_wr_req.rd_wr_en, mem_b_wr_req.rd_wr_en}),
                    96'({4{RW_IDLE}}), {when_s, ": request modes"});
        check_value(96'({skdecode_done, s1_done, s2_done, t0_done, skdecode_error}),
                    96'(5'b10000), {when_s, ": done and error flags"});
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    // Random s1, s2 and t0 values packed little-endian after the base
    task automatic load_key(input case_t tc);
        kword_t img [KEY_WORDS];
        int     v;
        int     w;
        int     pos;
        int     bad_idx;
        for (int i = 0; i < 1024; i++)
            kmem[i] = 32'h9e37_0000 | 32'(i);
        for (int i = 0; i < KEY_WORDS; i++)
            img[i] = '0;
        bad_idx = $urandom % (L * N);
        pos = 0;
        for (int c = 0; c < N_COEFFS; c++) begin
            if (c < S_COEFFS) begin
                v = $urandom % 5;
                if (tc.bad && c == bad_idx)
                    v = 5 + $urandom % 3;
                w = 3;
                exp_coeff[c] = ref_coeff(2, v);
            end else begin
                v = $urandom % 8192;
                w = 13;
                exp_coeff[c] = ref_coeff(4096, v);
            end
            for (int b = 0; b < w; b++) begin
                img[pos / 32][pos % 32] = v[b];
                pos++;
            end
        end
        for (int i = 0; i < KEY_WORDS; i++)
            kmem[int'(tc.src) + i] = img[i];
    endtask

    task automatic clear_banks();
        @(negedge clk);
        bank_clear = 1'b1;
        @(negedge clk);
        bank_clear = 1'b0;
    endtask

    task automatic start_run(input case_t tc);
        @(negedge clk);
        src_base_addr   = tc.src;
        dest_base_addr  = tc.dest;
        skdecode_enable = 1'b1;
        @(negedge clk);
        skdecode_enable = 1'b0;
        check_value(96'({skdecode_done, s1_done, s2_done, t0_done}), 96'(4'b0000),
                    "flags after start");
    endtask

    // Group g lives in bank g[0] at dest + g/2
    task automatic check_banks(input case_t tc);
        dword_t exp_w;
        dword_t got;
        int     addr;
        for (int g = 0; g < N_GROUPS; g++) begin
            exp_w = {exp_coeff[4*g+3], exp_coeff[4*g+2], exp_coeff[4*g+1], exp_coeff[4*g]};
            addr  = int'(tc.dest) + g / 2;
            got   = g[0] ? bank_b[addr] : bank_a[addr];
            check_value(got, exp_w, $sformatf("group %0d at address %03h", g, addr));
        end
        addr = int'(tc.dest) + N_GROUPS / 2;
        check_value(bank_a[addr], fill_word(0, addr), "bank a past the last group");
        check_value(bank_b[addr], fill_word(1, addr), "bank b past the last group");
    endtask

    task automatic run_case(input int idx, input case_t tc);
        int extra;
        load_key(tc);
        clear_banks();
        if (tc.zmid) begin
            start_run(tc);
            wait_s1_done();
            extra = $urandom % 12;
            repeat (extra) @(negedge clk);
            zeroize = 1'b1;
            @(negedge clk);
            zeroize = 1'b0;
            check_idle($sformatf("case %0d after zeroize", idx));
            clear_banks();
        end
        start_run(tc);
        wait_run_end();
        check_value(96'(skdecode_error), 96'(tc.bad),
                    $sformatf("case %0d skdecode_error", idx));
        check_banks(tc);
    endtask

    initial begin
        void'($urandom(32'h866e));
        zeroize         = 1'b0;
        skdecode_enable = 1'b0;
        src_base_addr   = '0;
        dest_base_addr  = '0;
        wait_reset_release();
        check_idle("after reset");
        for (int i = 0; i < NUM_CASES; i++)
            run_case(i, cases[i]);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== skdecode_top.f ====
hdl/skdecode_pkg.sv
hdl/skdecode_ctrl.sv
hdl/skdecode_s1s2_unpack.sv
hdl/skdecode_t0_unpack.sv
hdl/skdecode_top.sv
bench/skdecode_clkgen.sv
bench/skdecode_props.sv
bench/skdecode_tb.sv

// ==== build_sim.sh ====
#!/bin/sh
# Builds the secret-key decode testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module skdecode_tb \
    -f skdecode_top.f \
    -o skdecode_sim

status=0
./obj_dir/skdecode_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi
echo "Simulation finished cleanly"
